// ==== lsu_params.svh ====
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// data and address width
`define LSU_XLEN 32

// reorder-buffer index and register address widths
`define LSU_ROB_IDX_W 4
`define LSU_REG_W 5

// data memory depth in words
`define LSU_DMEM_WORDS 256

// edges from memory accept to response, 1 or more
`define LSU_DMEM_LATENCY 2

`endif

// ==== lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

        // load kinds, encoded like the RV32I load funct3 field
        typedef enum logic [2:0] {
                mem_op_b  = 3'b000,
                mem_op_h  = 3'b001,
                mem_op_w  = 3'b010,
                mem_op_bu = 3'b100,
                mem_op_hu = 3'b101
        } mem_op_t;

        // controller states
        // one access in flight, so a single wait state per kind
        typedef enum logic [1:0] {
                st_idle       = 2'd0,
                st_load_wait  = 2'd1,
                st_store_wait = 2'd2
        } lsu_state_t;

endpackage

`default_nettype wire

// ==== load_extract.sv ====
`default_nettype none

`include "lsu_params.svh"

module load_extract
        import lsu_pkg::*;
(
        input  wire logic [`LSU_XLEN-1:0] rdata_i,
        input  wire logic [1:0]           offset_i,
        input  wire mem_op_t              memop_i,
        output logic [`LSU_XLEN-1:0]      data_o
);

        logic [7:0]  sel_byte;
        logic [15:0] sel_half;

        // byte lane picked by the full offset
        assign sel_byte = rdata_i[{offset_i, 3'b000} +: 8];
        // halfwords are naturally aligned, only the upper offset bit matters
        assign sel_half = rdata_i[{offset_i[1], 4'b0000} +: 16];

        always_comb begin
                case (memop_i)
                        mem_op_b: begin
                                data_o = {{(`LSU_XLEN-8){sel_byte[7]}}, sel_byte};
                        end
                        mem_op_bu: begin
                                data_o = {{(`LSU_XLEN-8){1'b0}}, sel_byte};
                        end
                        mem_op_h: begin
                                data_o = {{(`LSU_XLEN-16){sel_half[15]}}, sel_half};
                        end
                        mem_op_hu: begin
                                data_o = {{(`LSU_XLEN-16){1'b0}}, sel_half};
                        end
                        default: begin
                                // word load
                                data_o = rdata_i;
                        end
                endcase
        end

endmodule

`default_nettype wire

// ==== mem_unit.sv ====
`default_nettype none

`include "lsu_params.svh"

module mem_unit
        import lsu_pkg::*;
(
        input  wire logic                      clk,
        input  wire logic                      rst,
        output logic                           busy_o,

        // load issue from the reservation station
        input  wire logic                      ld_valid_i,
        input  wire logic [`LSU_XLEN-1:0]      ld_rs1_data_i,
        input  wire logic [`LSU_XLEN-1:0]      ld_imm_i,
        input  wire mem_op_t                   ld_memop_i,
        input  wire logic [`LSU_REG_W-1:0]     ld_rd_addr_i,
        input  wire logic [`LSU_ROB_IDX_W-1:0] ld_rob_idx_i,

        // store commit from the rob head
        input  wire logic                      st_commit_i,
        input  wire logic [`LSU_XLEN-1:0]      st_addr_i,
        input  wire logic [3:0]                st_wmask_i,
        input  wire logic [`LSU_XLEN-1:0]      st_wdata_i,

        // data memory side
        output logic [`LSU_XLEN-1:0]           dmem_addr_o,
        output logic [3:0]                     dmem_rmask_o,
        output logic [3:0]                     dmem_wmask_o,
        output logic [`LSU_XLEN-1:0]           dmem_wdata_o,
        input  wire logic [`LSU_XLEN-1:0]      dmem_rdata_i,
        input  wire logic                      dmem_resp_i,

        // results
        output logic                           wb_valid_o,
        output logic [`LSU_REG_W-1:0]          wb_rd_addr_o,
        output logic [`LSU_ROB_IDX_W-1:0]      wb_rob_idx_o,
        output logic [`LSU_XLEN-1:0]           wb_data_o,
        output logic                           st_done_o
);

        lsu_state_t                    state;
        logic [`LSU_XLEN-1:0]          ld_addr;
        logic [3:0]                    ld_mask_base;
        mem_op_t                       memop_q;
        logic [1:0]                    offset_q;
        logic [`LSU_REG_W-1:0]         rd_q;
        logic [`LSU_ROB_IDX_W-1:0]     rob_q;

        // effective address of the incoming load
        assign ld_addr = ld_rs1_data_i + ld_imm_i;

        // unshifted byte mask for the access size
        always_comb begin
                case (ld_memop_i)
                        mem_op_b, mem_op_bu: ld_mask_base = 4'b0001;
                        mem_op_h, mem_op_hu: ld_mask_base = 4'b0011;
                        default:             ld_mask_base = 4'b1111;
                endcase
        end

        // control: state and request masks
        always_ff @(posedge clk) begin
                if (rst) begin
                        state        <= st_idle;
                        dmem_rmask_o <= '0;
                        dmem_wmask_o <= '0;
                end else begin
                        case (state)
                                st_idle: begin
                                        // commit wins over a load in the same cycle
                                        if (st_commit_i) begin
                                                state        <= st_store_wait;
                                                dmem_wmask_o <= st_wmask_i;
                                        end else if (ld_valid_i) begin
                                                state        <= st_load_wait;
                                                dmem_rmask_o <= ld_mask_base << ld_addr[1:0];
                                        end
                                end
                                st_load_wait, st_store_wait: begin
                                        if (dmem_resp_i) begin
                                                state        <= st_idle;
                                                dmem_rmask_o <= '0;
                                                dmem_wmask_o <= '0;
                                        end
                                end
                                default: begin
                                        state <= st_idle;
                                end
                        endcase
                end
        end

        // payload, captured only when a request is taken
        always_ff @(posedge clk) begin
                if (state == st_idle) begin
                        if (st_commit_i) begin
                                dmem_addr_o  <= st_addr_i;
                                dmem_wdata_o <= st_wdata_i;
                        end else if (ld_valid_i) begin
                                dmem_addr_o  <= {ld_addr[`LSU_XLEN-1:2], 2'b00};
                                dmem_wdata_o <= '0;
                                memop_q      <= ld_memop_i;
                                offset_q     <= ld_addr[1:0];
                                rd_q         <= ld_rd_addr_i;
                                rob_q        <= ld_rob_idx_i;
                        end
                end
        end

        load_extract u_extract (
                .rdata_i  (dmem_rdata_i),
                .offset_i (offset_q),
                .memop_i  (memop_q),
                .data_o   (wb_data_o)
        );

        assign busy_o       = (state != st_idle);
        // results follow the response pulse directly
        assign wb_valid_o   = (state == st_load_wait) && dmem_resp_i;
        assign st_done_o    = (state == st_store_wait) && dmem_resp_i;
        assign wb_rd_addr_o = rd_q;
        assign wb_rob_idx_o = rob_q;

endmodule

`default_nettype wire

// ==== dmem_sram.sv ====
`default_nettype none

`include "lsu_params.svh"

module dmem_sram (
        input  wire logic                 clk,
        input  wire logic                 rst,
        input  wire logic [`LSU_XLEN-1:0] addr_i,
        input  wire logic [3:0]           rmask_i,
        input  wire logic [3:0]           wmask_i,
        input  wire logic [`LSU_XLEN-1:0] wdata_i,
        output logic [`LSU_XLEN-1:0]      rdata_o,
        output logic                      resp_o
);

        localparam int IDX_W = $clog2(`LSU_DMEM_WORDS);
        localparam int LAT   = `LSU_DMEM_LATENCY;
        localparam int CNT_W = (LAT > 1) ? $clog2(LAT) : 1;

        logic [`LSU_XLEN-1:0] mem [`LSU_DMEM_WORDS];

        logic                 busy;
        logic [CNT_W-1:0]     cnt;
        logic                 start;
        logic                 fire;
        logic [IDX_W-1:0]     req_idx;
        logic [3:0]           req_wmask;
        logic [`LSU_XLEN-1:0] req_wdata;
        logic [IDX_W-1:0]     cur_idx;
        logic [3:0]           cur_wmask;
        logic [`LSU_XLEN-1:0] cur_wdata;

        // idle also excludes the response cycle, masks are still up then
        assign start = !busy && !resp_o && (|{rmask_i, wmask_i});
        assign fire  = (start && (LAT == 1)) || (busy && (cnt == '0));

        // live request for single-cycle latency, latched copy otherwise
        assign cur_idx   = busy ? req_idx   : addr_i[IDX_W+1:2];
        assign cur_wmask = busy ? req_wmask : wmask_i;
        assign cur_wdata = busy ? req_wdata : wdata_i;

        always_ff @(posedge clk) begin
                if (rst) begin
                        busy   <= 1'b0;
                        cnt    <= '0;
                        resp_o <= 1'b0;
                end else begin
                        resp_o <= fire;
                        if (start && (LAT > 1)) begin
                                busy <= 1'b1;
                                cnt  <= CNT_W'(LAT - 2);
                        end else if (busy) begin
                                if (cnt == '0) begin
                                        busy <= 1'b0;
                                end else begin
                                        cnt <= cnt - 1'b1;
                                end
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (start) begin
                        req_idx   <= addr_i[IDX_W+1:2];
                        req_wmask <= wmask_i;
                        req_wdata <= wdata_i;
                end
        end

        // array, zeroed during reset
        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int i = 0; i < `LSU_DMEM_WORDS; i++) begin
                                mem[i] <= '0;
                        end
                end else if (fire) begin
                        if (|cur_wmask) begin
                                for (int b = 0; b < 4; b++) begin
                                        if (cur_wmask[b]) begin
                                                mem[cur_idx][8*b +: 8] <= cur_wdata[8*b +: 8];
                                        end
                                end
                        end else begin
                                rdata_o <= mem[cur_idx];
                        end
                end
        end

endmodule

`default_nettype wire

// ==== lsu_top.sv ====
`default_nettype none

`include "lsu_params.svh"

module lsu_top
        import lsu_pkg::*;
(
        input  wire logic                      clk,
        input  wire logic                      rst,
        output logic                           busy_o,

        input  wire logic                      ld_valid_i,
        input  wire logic [`LSU_XLEN-1:0]      ld_rs1_data_i,
        input  wire logic [`LSU_XLEN-1:0]      ld_imm_i,
        input  wire mem_op_t                   ld_memop_i,
        input  wire logic [`LSU_REG_W-1:0]     ld_rd_addr_i,
        input  wire logic [`LSU_ROB_IDX_W-1:0] ld_rob_idx_i,

        input  wire logic                      st_commit_i,
        input  wire logic [`LSU_XLEN-1:0]      st_addr_i,
        input  wire logic [3:0]                st_wmask_i,
        input  wire logic [`LSU_XLEN-1:0]      st_wdata_i,

        output logic                           wb_valid_o,
        output logic [`LSU_REG_W-1:0]          wb_rd_addr_o,
        output logic [`LSU_ROB_IDX_W-1:0]      wb_rob_idx_o,
        output logic [`LSU_XLEN-1:0]           wb_data_o,
        output logic                           st_done_o
);

        // controller to memory
        logic [`LSU_XLEN-1:0] dmem_addr;
        logic [3:0]           dmem_rmask;
        logic [3:0]           dmem_wmask;
        logic [`LSU_XLEN-1:0] dmem_wdata;
        logic [`LSU_XLEN-1:0] dmem_rdata;
        logic                 dmem_resp;

        mem_unit u_mem_unit (
                .clk           (clk),
                .rst           (rst),
                .busy_o        (busy_o),
                .ld_valid_i    (ld_valid_i),
                .ld_rs1_data_i (ld_rs1_data_i),
                .ld_imm_i      (ld_imm_i),
                .ld_memop_i    (ld_memop_i),
                .ld_rd_addr_i  (ld_rd_addr_i),
                .ld_rob_idx_i  (ld_rob_idx_i),
                .st_commit_i   (st_commit_i),
                .st_addr_i     (st_addr_i),
                .st_wmask_i    (st_wmask_i),
                .st_wdata_i    (st_wdata_i),
                .dmem_addr_o   (dmem_addr),
                .dmem_rmask_o  (dmem_rmask),
                .dmem_wmask_o  (dmem_wmask),
                .dmem_wdata_o  (dmem_wdata),
                .dmem_rdata_i  (dmem_rdata),
                .dmem_resp_i   (dmem_resp),
                .wb_valid_o    (wb_valid_o),
                .wb_rd_addr_o  (wb_rd_addr_o),
                .wb_rob_idx_o  (wb_rob_idx_o),
                .wb_data_o     (wb_data_o),
                .st_done_o     (st_done_o)
        );

        dmem_sram u_dmem (
                .clk     (clk),
                .rst     (rst),
                .addr_i  (dmem_addr),
                .rmask_i (dmem_rmask),
                .wmask_i (dmem_wmask),
                .wdata_i (dmem_wdata),
                .rdata_o (dmem_rdata),
                .resp_o  (dmem_resp)
        );

endmodule

`default_nettype wire

// ==== lsu_chk.sv ====
`default_nettype none

`include "lsu_params.svh"

module lsu_chk (
        input wire logic                 clk,
        input wire logic                 rst,
        input wire logic                 busy_i,
        input wire logic [3:0]           rmask_i,
        input wire logic [3:0]           wmask_i,
        input wire logic [`LSU_XLEN-1:0] addr_i,
        input wire logic                 resp_i,
        input wire logic                 wb_valid_i,
        input wire logic                 st_done_i
);

        int unsigned fail_count = 0;
        logic        req;

        // a request is any cycle with a nonzero mask
        assign req = |{rmask_i, wmask_i};

        a_one_mask: assert property (@(posedge clk) disable iff (rst)
                !((|rmask_i) && (|wmask_i)))
        else begin
                $error("read and write masks both nonzero");
                fail_count++;
        end

        a_one_result: assert property (@(posedge clk) disable iff (rst)
                !(wb_valid_i && st_done_i))
        else begin
                $error("writeback and store done in the same cycle");
                fail_count++;
        end

        a_wb_pulse: assert property (@(posedge clk) disable iff (rst)
                wb_valid_i |=> !wb_valid_i)
        else begin
                $error("writeback longer than one cycle");
                fail_count++;
        end

        a_st_pulse: assert property (@(posedge clk) disable iff (rst)
                st_done_i |=> !st_done_i)
        else begin
                $error("store done longer than one cycle");
                fail_count++;
        end

        // new request only out of idle
        a_no_accept_busy: assert property (@(posedge clk) disable iff (rst)
                $rose(req) |-> $past(!busy_i))
        else begin
                $error("request started while busy");
                fail_count++;
        end

        a_req_stable: assert property (@(posedge clk) disable iff (rst)
                req && !resp_i |=> $stable({rmask_i, wmask_i, addr_i}))
        else begin
                $error("request changed before response");
                fail_count++;
        end

endmodule

bind lsu_top lsu_chk u_chk (
        .clk        (clk),
        .rst        (rst),
        .busy_i     (busy_o),
        .rmask_i    (dmem_rmask),
        .wmask_i    (dmem_wmask),
        .addr_i     (dmem_addr),
        .resp_i     (dmem_resp),
        .wb_valid_i (wb_valid_o),
        .st_done_i  (st_done_o)
);

`default_nettype wire

// ==== tb_lsu.sv ====
`default_nettype none

`include "lsu_params.svh"

module tb_lsu;
        import lsu_pkg::*;

        localparam int TIMEOUT = 20;

        logic                      clk;
        logic                      rst;
        logic                      busy_o;
        logic                      ld_valid_i;
        logic [`LSU_XLEN-1:0]      ld_rs1_data_i;
        logic [`LSU_XLEN-1:0]      ld_imm_i;
        mem_op_t                   ld_memop_i;
        logic [`LSU_REG_W-1:0]     ld_rd_addr_i;
        logic [`LSU_ROB_IDX_W-1:0] ld_rob_idx_i;
        logic                      st_commit_i;
        logic [`LSU_XLEN-1:0]      st_addr_i;
        logic [3:0]                st_wmask_i;
        logic [`LSU_XLEN-1:0]      st_wdata_i;
        logic                      wb_valid_o;
        logic [`LSU_REG_W-1:0]     wb_rd_addr_o;
        logic [`LSU_ROB_IDX_W-1:0] wb_rob_idx_o;
        logic [`LSU_XLEN-1:0]      wb_data_o;
        logic                      st_done_o;

        // reference copy of the data memory
        logic [31:0] ref_mem [`LSU_DMEM_WORDS];
        integer      seed;
        int          checks = 0;
        int          errors = 0;
        int          tests = 0;
        int          errs_at_start = 0;

        lsu_top dut (.*);

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        task automatic check(input bit ok, input string msg);
                checks++;
                assert (ok) else begin
                        $display("mismatch at %0t: %s", $time, msg);
                        errors++;
                end
        endtask

        task automatic abort_run(input string what);
                $display("timeout: no %s within %0d cycles", what, TIMEOUT);
                $display("=== FAIL ===");
                $finish;
        endtask

        task automatic wait_idle();
                int n;
                n = 0;
                while (busy_o) begin
                        @(negedge clk);
                        n++;
                        if (n > TIMEOUT) abort_run("busy_o release");
                end
        endtask

        // strobes already driven, keep stray strobes up while busy
        // and wait for the matching pulse
        task automatic wait_result(input bit is_load);
                int n;
                bit got;
                n = 0;
                do begin
                        @(negedge clk);
                        n++;
                        check(!(is_load ? st_done_o : wb_valid_o), "pulse of the wrong kind");
                        got = is_load ? wb_valid_o : st_done_o;
                        // requests while busy must be ignored
                        ld_valid_i = busy_o && !got;
                        st_commit_i = busy_o && !got;
                        if (!got && n > TIMEOUT) begin
                                abort_run(is_load ? "load writeback" : "store done");
                        end
                end while (!got);
                check(n == 1 + `LSU_DMEM_LATENCY, $sformatf("result after %0d edges", n));
        endtask

        function automatic logic [31:0] expect_load(input logic [31:0] addr, input mem_op_t op);
                logic [31:0] w;
                logic [31:0] sh;
                w = ref_mem[addr[9:2]];
                sh = w >> (8 * addr[1:0]);
                case (op)
                        mem_op_b:  return {{24{sh[7]}}, sh[7:0]};
                        mem_op_bu: return {24'd0, sh[7:0]};
                        mem_op_h:  return {{16{sh[15]}}, sh[15:0]};
                        mem_op_hu: return {16'd0, sh[15:0]};
                        default:   return w;
                endcase
        endfunction

        function automatic mem_op_t pick_op(input int k);
                case (k)
                        0:       return mem_op_b;
                        1:       return mem_op_bu;
                        2:       return mem_op_h;
                        3:       return mem_op_hu;
                        default: return mem_op_w;
                endcase
        endfunction

        task automatic store_commit(input logic [31:0] addr, input logic [3:0] mask,
                                    input logic [31:0] data, input bit with_load);
                wait_idle();
                st_commit_i = 1'b1;
                st_addr_i = {addr[31:2], 2'b00};
                st_wmask_i = mask;
                st_wdata_i = data;
                ld_valid_i = with_load;
                wait_result(1'b0);
                for (int i = 0; i < 4; i++) begin
                        if (mask[i]) ref_mem[addr[9:2]][8*i +: 8] = data[8*i +: 8];
                end
        endtask

        task automatic load_check(input logic [31:0] addr, input mem_op_t op,
                                  input logic [4:0] rd, input logic [3:0] rob);
                logic [31:0] r;
                logic [31:0] imm;
                logic [31:0] exp;
                r = $random(seed);
                imm = {{20{r[11]}}, r[11:0]};
                exp = expect_load(addr, op);
                wait_idle();
                ld_valid_i = 1'b1;
                ld_rs1_data_i = addr - imm;
                ld_imm_i = imm;
                ld_memop_i = op;
                ld_rd_addr_i = rd;
                ld_rob_idx_i = rob;
                wait_result(1'b1);
                check(wb_data_o === exp, $sformatf("%s at %h gave %h, expected %h",
                      op.name(), addr, wb_data_o, exp));
                check(wb_rd_addr_o === rd && wb_rob_idx_o === rob, "writeback tag");
        endtask

        task automatic end_test(input string name);
                $display("test %-10s done, %0d errors", name, errors - errs_at_start);
                errs_at_start = errors;
                tests++;
        endtask

        initial begin
                logic [31:0] addr;
                logic [31:0] r;
                logic [3:0]  m;
                mem_op_t     op;
                seed = 32'h2328ec42;
                rst = 1'b1;
                ld_valid_i = 1'b0;
                ld_rs1_data_i = '0;
                ld_imm_i = '0;
                ld_memop_i = mem_op_w;
                ld_rd_addr_i = '0;
                ld_rob_idx_i = '0;
                st_commit_i = 1'b0;
                st_addr_i = '0;
                st_wmask_i = '0;
                st_wdata_i = '0;
                for (int i = 0; i < `LSU_DMEM_WORDS; i++) ref_mem[i] = '0;
                repeat (2) @(negedge clk);
                rst = 1'b0;

                check(!busy_o && !wb_valid_o && !st_done_o, "outputs not idle after reset");
                for (int i = 0; i < 4; i++) begin
                        r = $random(seed);
                        load_check(r & 32'h3fc, mem_op_w, 5'(i), 4'(i));
                end
                end_test("reset");

                for (int i = 0; i < 8; i++) begin
                        store_commit(32'(i * 116 + 4), 4'hf, $random(seed), 1'b0);
                end
                for (int i = 0; i < 8; i++) begin
                        load_check(32'(i * 116 + 4), mem_op_w, 5'(i + 1), 4'(i));
                end
                end_test("word");

                // bytes with the top bit set exercise sign extension
                store_commit(32'h100, 4'hf, 32'h80f1_7f9c, 1'b0);
                store_commit(32'h100, 4'b0110, 32'h00e4_b200, 1'b0);
                for (int off = 0; off < 4; off++) begin
                        load_check(32'h100 + 32'(off), mem_op_b, 5'd3, 4'd1);
                        load_check(32'h100 + 32'(off), mem_op_bu, 5'd4, 4'd2);
                        if (off % 2 == 0) begin
                                load_check(32'h100 + 32'(off), mem_op_h, 5'd5, 4'd3);
                                load_check(32'h100 + 32'(off), mem_op_hu, 5'd6, 4'd4);
                        end
                end
                load_check(32'h100, mem_op_w, 5'd7, 4'd5);
                end_test("partial");

                ld_rs1_data_i = 32'h200;
                ld_imm_i = '0;
                ld_memop_i = mem_op_w;
                ld_rd_addr_i = 5'd9;
                ld_rob_idx_i = 4'd6;
                store_commit(32'h200, 4'hf, $random(seed), 1'b1);
                load_check(32'h200, mem_op_w, 5'd9, 4'd6);
                end_test("collision");

                for (int i = 0; i < 200; i++) begin
                        r = $random(seed);
                        addr = r & 32'h3ff;
                        if (r[31]) begin
                                m = (r[15:12] == 4'd0) ? 4'hf : r[15:12];
                                store_commit(addr, m, $random(seed), 1'b0);
                        end else begin
                                op = pick_op(int'(r[30:28]) % 5);
                                if (op == mem_op_w) addr[1:0] = 2'b00;
                                else if (op == mem_op_h || op == mem_op_hu) addr[0] = 1'b0;
                                load_check(addr, op, r[20:16], r[24:21]);
                        end
                end
                end_test("random");

                $display("tests %0d, checks %0d, errors %0d, protocol errors %0d",
                         tests, checks, errors, dut.u_chk.fail_count);
                if (errors == 0 && dut.u_chk.fail_count == 0) begin
                        $display("=== PASS ===");
                end else begin
                        $display("=== FAIL ===");
                end
                $finish;
        end

endmodule

`default_nettype wire

// ==== lsu.f ====
+incdir+.
lsu_pkg.sv
load_extract.sv
mem_unit.sv
dmem_sram.sv
lsu_top.sv
lsu_chk.sv
tb_lsu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_lsu
FILELIST  ?= lsu.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  := === FAIL ===
PASS_MSG  := === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qF "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
